//--- Bender.yml
package:
  name: mmu

sources:
  - design/mmu_pkg.sv
  - design/tlb_array.sv
  - design/tlb_lookup.sv
  - design/mmu_ctrl.sv
  - design/mmu_top.sv
  - target: test
    files:
      - test/mmu_checker.sv
      - test/mmu_tb.sv

//--- design/mmu_ctrl.sv
module mmu_ctrl (
    input  logic                           clk,
    input  logic                           rst,
    // data port
    input  logic                           dreq_valid_i,
    input  mmu_pkg::dreq_t                 dreq_i,
    output logic                           dcredit_o,
    output logic                           dresp_valid_o,
    output mmu_pkg::lookup_rsp_t           dresp_o,
    input  logic                           flush_i,
    // cp0 commands
    input  logic                           cmd_valid_i,
    input  mmu_pkg::tlb_cmd_t              cmd_i,
    output logic                           cmd_rsp_valid_o,
    output mmu_pkg::tlb_cmd_rsp_t          cmd_rsp_o,
    // lookup instances
    output logic [31:0]                    data_va_o,
    output logic [31:0]                    probe_va_o,
    input  mmu_pkg::lookup_rsp_t           data_rsp_i,
    input  mmu_pkg::lookup_rsp_t           probe_rsp_i,
    output logic [7:0]                     asid_o,
    // array
    output logic                           we_o,
    output logic [mmu_pkg::IDX_BITS-1:0]   idx_o,
    output mmu_pkg::tlb_entry_t            wentry_o,
    input  mmu_pkg::tlb_entry_t            rentry_i
);

    function automatic mmu_pkg::tlb_page_t pack_page(mmu_pkg::entrylo_t lo,
                                                     logic [11:0] mask);
        mmu_pkg::tlb_page_t pg;
        pg.pfn = lo.pfn & {8'hff, ~mask};
        pg.c   = lo.c;
        pg.d   = lo.d;
        pg.v   = lo.v;
        return pg;
    endfunction

    function automatic mmu_pkg::entrylo_t unpack_lo(mmu_pkg::tlb_page_t pg, logic g);
        mmu_pkg::entrylo_t lo;
        lo.zero = '0;
        lo.pfn  = pg.pfn;
        lo.c    = pg.c;
        lo.d    = pg.d;
        lo.v    = pg.v;
        lo.g    = g;
        return lo;
    endfunction

    function automatic logic entry_hits(mmu_pkg::tlb_entry_t e, mmu_pkg::entryhi_t hi);
        return (((hi.vpn2 ^ e.vpn2) & {7'h7f, ~e.mask}) == '0) &&
               (e.g || (e.asid == hi.asid));
    endfunction

    localparam int CNT_BITS = mmu_pkg::DREQ_PTR_BITS + 1;

    logic                              cmd_go;
    logic                              deq;
    logic                              q_full;
    logic [mmu_pkg::DREQ_PTR_BITS-1:0] wr_ptr_q;
    logic [mmu_pkg::DREQ_PTR_BITS-1:0] rd_ptr_q;
    logic [CNT_BITS-1:0]               count_q;
    mmu_pkg::dreq_t                    q_mem [mmu_pkg::DREQ_DEPTH];

    mmu_pkg::entryhi_t                 ehi_q;
    mmu_pkg::tlb_entry_t               rd_q;
    logic                              rsp_valid_q;
    logic                              probe_q;
    logic                              dcredit_q;
    logic                              dresp_valid_q;
    mmu_pkg::lookup_rsp_t              dresp_q;

    // a command owns the array for its cycle
    assign cmd_go = cmd_valid_i && (cmd_i.op != mmu_pkg::CMD_NONE);
    assign q_full = (count_q == CNT_BITS'(mmu_pkg::DREQ_DEPTH));
    assign deq    = (count_q != '0) && !cmd_go;

    assign we_o = cmd_go && (cmd_i.op == mmu_pkg::CMD_TLBWI);

    // outside command cycles point the read port at the probe result
    assign idx_o = cmd_go ? cmd_i.idx : probe_rsp_i.idx;

    always_comb begin
        wentry_o.mask    = cmd_i.mask;
        wentry_o.vpn2    = cmd_i.hi.vpn2 & {7'h7f, ~cmd_i.mask};
        wentry_o.asid    = cmd_i.hi.asid;
        wentry_o.g       = cmd_i.lo0.g & cmd_i.lo1.g;
        wentry_o.page[0] = pack_page(cmd_i.lo0, cmd_i.mask);
        wentry_o.page[1] = pack_page(cmd_i.lo1, cmd_i.mask);
    end

    assign asid_o     = ehi_q.asid;
    assign probe_va_o = {ehi_q.vpn2, 13'h0000};
    assign data_va_o  = q_mem[rd_ptr_q].va;

    always_comb begin
        cmd_rsp_o.mask    = rd_q.mask;
        cmd_rsp_o.hi.vpn2 = rd_q.vpn2;
        cmd_rsp_o.hi.zero = '0;
        cmd_rsp_o.hi.asid = rd_q.asid;
        cmd_rsp_o.lo0     = unpack_lo(rd_q.page[0], rd_q.g);
        cmd_rsp_o.lo1     = unpack_lo(rd_q.page[1], rd_q.g);
        // probe runs in the reply cycle against the loaded entryhi
        cmd_rsp_o.probe   = {probe_rsp_i.miss, {(31 - mmu_pkg::IDX_BITS){1'b0}},
                             probe_rsp_i.idx};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ehi_q         <= '0;
            rsp_valid_q   <= 1'b0;
            probe_q       <= 1'b0;
            wr_ptr_q      <= '0;
            rd_ptr_q      <= '0;
            count_q       <= '0;
            dcredit_q     <= 1'b0;
            dresp_valid_q <= 1'b0;
        end else begin
            // live entryhi follows write and probe commands
            if (cmd_go && (cmd_i.op != mmu_pkg::CMD_TLBR)) begin
                ehi_q <= cmd_i.hi;
            end
            rsp_valid_q <= cmd_go && ((cmd_i.op == mmu_pkg::CMD_TLBR) ||
                                      (cmd_i.op == mmu_pkg::CMD_TLBP));
            probe_q     <= cmd_go && (cmd_i.op == mmu_pkg::CMD_TLBP);

            if (dreq_valid_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (deq) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({dreq_valid_i, deq})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase

            // credit comes back even for a flushed result
            dcredit_q     <= deq;
            dresp_valid_q <= deq && !flush_i;
        end
    end

    always_ff @(posedge clk) begin
        if (dreq_valid_i) begin
            q_mem[wr_ptr_q] <= dreq_i;
        end
        if (deq) begin
            dresp_q <= data_rsp_i;
        end
        if (cmd_go && (cmd_i.op == mmu_pkg::CMD_TLBR)) begin
            rd_q <= rentry_i;
        end
    end

    assign dcredit_o       = dcredit_q;
    assign dresp_valid_o   = dresp_valid_q;
    assign dresp_o         = dresp_q;
    assign cmd_rsp_valid_o = rsp_valid_q;

    // requester sent without a credit
    a_no_enq_when_full: assert property (
        @(posedge clk) disable iff (rst)
        dreq_valid_i |-> !q_full
    ) else $error("data request while queue full");

    // hit index must name an entry that really matches, else several matched
    a_probe_single_match: assert property (
        @(posedge clk) disable iff (rst)
        (probe_q && !probe_rsp_i.miss && !cmd_go) |-> entry_hits(rentry_i, ehi_q)
    ) else $error("probe hit on index %0d with multiple matches", probe_rsp_i.idx);

    a_rsp_after_cmd: assert property (
        @(posedge clk) disable iff (rst)
        cmd_rsp_valid_o |-> $past(cmd_valid_i && ((cmd_i.op == mmu_pkg::CMD_TLBR) ||
                                                  (cmd_i.op == mmu_pkg::CMD_TLBP)))
    ) else $error("command reply without read or probe");

endmodule

//--- design/mmu_pkg.sv
package mmu_pkg;

    localparam int TLB_NUM       = 16;
    localparam int IDX_BITS      = 4;
    localparam int DREQ_DEPTH    = 2;
    localparam int DREQ_PTR_BITS = 1;

    // cp0 entryhi layout
    typedef struct packed {
        logic [18:0] vpn2;
        logic [4:0]  zero;
        logic [7:0]  asid;
    } entryhi_t;

    // cp0 entrylo0/entrylo1 layout
    typedef struct packed {
        logic [5:0]  zero;
        logic [19:0] pfn;
        logic [2:0]  c;
        logic        d;
        logic        v;
        logic        g;
    } entrylo_t;

    // one page of a stored pair
    typedef struct packed {
        logic [19:0] pfn;
        logic [2:0]  c;
        logic        d;
        logic        v;
    } tlb_page_t;

    // page[0] even, page[1] odd
    typedef struct packed {
        logic [11:0]        mask;
        logic [18:0]        vpn2;
        logic [7:0]         asid;
        logic               g;
        tlb_page_t [1:0]    page;
    } tlb_entry_t;

    typedef enum logic [1:0] {
        CMD_NONE  = 2'd0,
        CMD_TLBWI = 2'd1,
        CMD_TLBR  = 2'd2,
        CMD_TLBP  = 2'd3
    } tlb_cmd_e;

    typedef struct packed {
        tlb_cmd_e              op;
        logic [IDX_BITS-1:0]   idx;
        logic [11:0]           mask;
        entryhi_t              hi;
        entrylo_t              lo0;
        entrylo_t              lo1;
    } tlb_cmd_t;

    // probe word: bit 31 miss, index in low bits
    typedef struct packed {
        logic [11:0] mask;
        entryhi_t    hi;
        entrylo_t    lo0;
        entrylo_t    lo1;
        logic [31:0] probe;
    } tlb_cmd_rsp_t;

    typedef struct packed {
        logic                  miss;
        logic                  valid;
        logic                  dirty;
        logic [2:0]            c;
        logic [IDX_BITS-1:0]   idx;
        logic [31:0]           pa;
    } lookup_rsp_t;

    typedef struct packed {
        logic [31:0] va;
    } dreq_t;

endpackage

//--- design/mmu_top.sv
module mmu_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [31:0]             fetch_va_i,
    output mmu_pkg::lookup_rsp_t    fetch_rsp_o,
    input  logic                    dreq_valid_i,
    input  mmu_pkg::dreq_t          dreq_i,
    output logic                    dcredit_o,
    output logic                    dresp_valid_o,
    output mmu_pkg::lookup_rsp_t    dresp_o,
    input  logic                    flush_i,
    input  logic                    cmd_valid_i,
    input  mmu_pkg::tlb_cmd_t       cmd_i,
    output logic                    cmd_rsp_valid_o,
    output mmu_pkg::tlb_cmd_rsp_t   cmd_rsp_o
);

    mmu_pkg::tlb_entry_t             entries [mmu_pkg::TLB_NUM];
    mmu_pkg::tlb_entry_t             wentry;
    mmu_pkg::tlb_entry_t             rentry;
    logic                            we;
    logic [mmu_pkg::IDX_BITS-1:0]    idx;
    logic [7:0]                      asid;
    logic [31:0]                     data_va;
    logic [31:0]                     probe_va;
    mmu_pkg::lookup_rsp_t            data_rsp;
    mmu_pkg::lookup_rsp_t            probe_rsp;

    mmu_ctrl u_ctrl (
        .clk             (clk),
        .rst             (rst),
        .dreq_valid_i    (dreq_valid_i),
        .dreq_i          (dreq_i),
        .dcredit_o       (dcredit_o),
        .dresp_valid_o   (dresp_valid_o),
        .dresp_o         (dresp_o),
        .flush_i         (flush_i),
        .cmd_valid_i     (cmd_valid_i),
        .cmd_i           (cmd_i),
        .cmd_rsp_valid_o (cmd_rsp_valid_o),
        .cmd_rsp_o       (cmd_rsp_o),
        .data_va_o       (data_va),
        .probe_va_o      (probe_va),
        .data_rsp_i      (data_rsp),
        .probe_rsp_i     (probe_rsp),
        .asid_o          (asid),
        .we_o            (we),
        .idx_o           (idx),
        .wentry_o        (wentry),
        .rentry_i        (rentry)
    );

    tlb_array u_array (
        .clk       (clk),
        .rst       (rst),
        .we_i      (we),
        .idx_i     (idx),
        .wentry_i  (wentry),
        .rentry_o  (rentry),
        .entries_o (entries)
    );

    // fetch result leaves unregistered
    tlb_lookup u_lkp_fetch (
        .entries_i (entries),
        .va_i      (fetch_va_i),
        .asid_i    (asid),
        .rsp_o     (fetch_rsp_o)
    );

    tlb_lookup u_lkp_data (
        .entries_i (entries),
        .va_i      (data_va),
        .asid_i    (asid),
        .rsp_o     (data_rsp)
    );

    tlb_lookup u_lkp_probe (
        .entries_i (entries),
        .va_i      (probe_va),
        .asid_i    (asid),
        .rsp_o     (probe_rsp)
    );

endmodule

//--- design/tlb_array.sv
module tlb_array (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           we_i,
    input  logic [mmu_pkg::IDX_BITS-1:0]   idx_i,
    input  mmu_pkg::tlb_entry_t            wentry_i,
    output mmu_pkg::tlb_entry_t            rentry_o,
    output mmu_pkg::tlb_entry_t            entries_o [mmu_pkg::TLB_NUM]
);

    mmu_pkg::tlb_entry_t entries_q [mmu_pkg::TLB_NUM];

    // all entries invalid and non-global after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int n = 0; n < mmu_pkg::TLB_NUM; n++) begin
                entries_q[n] <= '0;
            end
        end else if (we_i) begin
            entries_q[idx_i] <= wentry_i;
        end
    end

    assign rentry_o  = entries_q[idx_i];
    assign entries_o = entries_q;

endmodule

//--- design/tlb_lookup.sv
module tlb_lookup (
    input  mmu_pkg::tlb_entry_t   entries_i [mmu_pkg::TLB_NUM],
    input  logic [31:0]           va_i,
    input  logic [7:0]            asid_i,
    output mmu_pkg::lookup_rsp_t  rsp_o
);

    logic [mmu_pkg::TLB_NUM-1:0] match;

    always_comb begin
        mmu_pkg::lookup_rsp_t acc;
        mmu_pkg::tlb_page_t   pg;
        logic [18:0]          cmp_m;
        logic [12:0]          odd_m;
        logic                 odd;
        logic [31:0]          pa;

        acc = '0;
        for (int i = 0; i < mmu_pkg::TLB_NUM; i++) begin
            // vpn2 bits under the mask are don't care
            cmp_m    = {7'h7f, ~entries_i[i].mask};
            match[i] = (((va_i[31:13] ^ entries_i[i].vpn2) & cmp_m) == '0) &&
                       (entries_i[i].g || (entries_i[i].asid == asid_i));

            // single bit just above the masked range picks the odd page
            odd_m = {entries_i[i].mask, 1'b1} & ~{1'b0, entries_i[i].mask};
            odd   = |(va_i[24:12] & odd_m);
            pg    = entries_i[i].page[odd];

            // pfn is stored pre-masked
            pa = {pg.pfn, 12'h000} | (va_i & {8'h00, entries_i[i].mask, 12'hfff});

            if (match[i]) begin
                acc.valid = acc.valid | pg.v;
                acc.dirty = acc.dirty | pg.d;
                acc.c     = acc.c | pg.c;
                acc.idx   = acc.idx | mmu_pkg::IDX_BITS'(i);
                acc.pa    = acc.pa | pa;
            end
        end
        acc.miss = ~|match;
        rsp_o    = acc;
    end

endmodule

//--- list.f
design/mmu_pkg.sv
design/tlb_array.sv
design/tlb_lookup.sv
design/mmu_ctrl.sv
design/mmu_top.sv
test/mmu_checker.sv
test/mmu_tb.sv

//--- test/mmu_checker.sv
module mmu_checker (
    input  logic                   clk,
    input  logic                   rst,
    input  mmu_pkg::lookup_rsp_t   fetch_rsp_i,
    input  logic                   dreq_valid_i,
    input  logic                   dcredit_i,
    input  logic                   dresp_valid_i,
    input  mmu_pkg::lookup_rsp_t   dresp_i,
    input  logic                   cmd_rsp_valid_i,
    input  mmu_pkg::tlb_cmd_rsp_t  cmd_rsp_i
);

    typedef struct packed {
        logic [31:0] pa;
        logic        miss;
        logic        valid;
        logic        dirty;
    } xlate_exp_t;

    xlate_exp_t            data_q [$];
    xlate_exp_t            fetch_exp;
    mmu_pkg::tlb_cmd_rsp_t cmd_exp;
    bit                    fetch_pend  = 1'b0;
    bit                    cmd_pend    = 1'b0;
    bit                    cmd_probe   = 1'b0;
    int                    outstanding = 0;
    int                    checks      = 0;
    int                    errors      = 0;

    task automatic flag_error(input string msg);
        errors++;
        $display("%0t: %s", $time, msg);
    endtask

    task automatic compare_word(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s is %08h, expected %08h", $time, what, got, exp);
        end
    endtask

    task automatic set_fetch(input logic [31:0] pa, input logic miss, input logic valid);
        fetch_exp  = {pa, miss, valid, 1'b0};
        fetch_pend = 1'b1;
    endtask

    task automatic push_data(input logic [31:0] pa, input logic miss, input logic valid,
                             input logic dirty);
        data_q.push_back({pa, miss, valid, dirty});
    endtask

    task automatic await_reply(input logic probe, input logic [11:0] mask,
                               input logic [31:0] hi, input logic [31:0] lo0,
                               input logic [31:0] lo1, input logic [31:0] word);
        cmd_exp   = {mask, hi, lo0, lo1, word};
        cmd_probe = probe;
        cmd_pend  = 1'b1;
    endtask

    function automatic int pending_data();
        return data_q.size();
    endfunction

    function automatic int error_total();
        return errors;
    endfunction

    task automatic print_counts();
        $display("checks %0d, errors %0d", checks, errors);
    endtask

    always @(posedge clk) begin
        xlate_exp_t e;
        if (!rst) begin
            if (fetch_pend) begin
                compare_word("fetch pa", fetch_rsp_i.pa, fetch_exp.pa);
                compare_word("fetch miss", fetch_rsp_i.miss, fetch_exp.miss);
                compare_word("fetch valid", fetch_rsp_i.valid, fetch_exp.valid);
                fetch_pend = 1'b0;
            end
            // results come back in request order
            if (dresp_valid_i && (data_q.size() == 0)) begin
                flag_error("data result arrived with no request waiting for one");
            end else if (dresp_valid_i) begin
                e = data_q.pop_front();
                compare_word("data pa", dresp_i.pa, e.pa);
                compare_word("data miss", dresp_i.miss, e.miss);
                compare_word("data valid", dresp_i.valid, e.valid);
                compare_word("data dirty", dresp_i.dirty, e.dirty);
            end
            if (dcredit_i && (outstanding == 0)) begin
                flag_error("data credit returned with no request outstanding");
            end else if (dcredit_i) begin
                outstanding--;
            end
            if (dreq_valid_i) begin
                outstanding++;
            end
            // reply due exactly one cycle after the command
            if (cmd_pend && !cmd_rsp_valid_i) begin
                flag_error("no reply in the cycle after a read or probe");
            end else if (cmd_pend && cmd_probe) begin
                compare_word("probe word", cmd_rsp_i.probe, cmd_exp.probe);
            end else if (cmd_pend) begin
                compare_word("read mask", cmd_rsp_i.mask, cmd_exp.mask);
                compare_word("read entryhi", cmd_rsp_i.hi, cmd_exp.hi);
                compare_word("read entrylo0", cmd_rsp_i.lo0, cmd_exp.lo0);
                compare_word("read entrylo1", cmd_rsp_i.lo1, cmd_exp.lo1);
            end else if (cmd_rsp_valid_i) begin
                flag_error("command reply with no read or probe before it");
            end
            cmd_pend = 1'b0;
        end
    end

endmodule

//--- test/mmu_golden.txt
# write idx mask entryhi lo0 lo1 | read idx mask entryhi lo0 lo1 (read words expected)
# fetch va pa miss valid | data va pa miss valid dirty flush | probe entryhi probe_word
write 0 000 00080011 000048de 00011593
read 0 000 00080011 000048de 00011592
write 5 000 00200022 0001ddc4 00022202
write 1 003 10006011 000281db 0002c21f
read 1 003 10000011 0002811b 0002c21f
read 5 000 00200022 0001ddc4 00022202
# asid 11 from the last write
fetch 00080abc 00123abc 0 1
fetch 00081def 00456def 0 1
fetch 10002345 00a06345 0 1
fetch 10007abc 00b0babc 0 1
fetch 00200123 00000000 1 0
fetch 30000000 00000000 1 0
probe 00080011 00000000
probe 10004011 00000001
probe 00300011 80000000
# data with commands in between
data 00080010 00123010 0 1 1 0
data 00081020 00456020 0 1 0 0
data 10002345 00a06345 0 1 0 0
read 0 000 00080011 000048de 00011592
data 10007abc 00b0babc 0 1 1 0
probe 00080011 00000000
data 30000000 00000000 1 0 0 0
data 00080444 00123444 0 1 1 1
data 00081555 00456555 0 1 0 0
fetch 00080abc 00123abc 0 1
# probe moves the live asid to 22
probe 00200022 00000005
fetch 00200123 00777123 0 0
fetch 00201abc 00888abc 0 1
fetch 00080abc 00000000 1 0
fetch 10002345 00a06345 0 1
data 00200456 00777456 0 0 1 0
data 10007000 00b0b000 0 1 1 0
data 00081000 00000000 1 0 0 0
read 5 000 00200022 0001ddc4 00022202

//--- test/mmu_tb.sv
module mmu_tb;

    localparam int WAIT_LIMIT = 100;

    logic                   clk;
    logic                   rst;
    logic [31:0]            fetch_va;
    mmu_pkg::lookup_rsp_t   fetch_rsp;
    logic                   dreq_valid;
    mmu_pkg::dreq_t         dreq;
    logic                   dcredit;
    logic                   dresp_valid;
    mmu_pkg::lookup_rsp_t   dresp;
    logic                   flush;
    logic                   cmd_valid;
    mmu_pkg::tlb_cmd_t      cmd;
    logic                   cmd_rsp_valid;
    mmu_pkg::tlb_cmd_rsp_t  cmd_rsp;

    int                     credits;
    bit                     aborted;
    int                     fd;
    int                     code;
    logic [8*8-1:0]         kind;
    logic [8*128-1:0]       rest;
    logic [31:0]            f [6];

    mmu_top u_dut (
        .clk             (clk),
        .rst             (rst),
        .fetch_va_i      (fetch_va),
        .fetch_rsp_o     (fetch_rsp),
        .dreq_valid_i    (dreq_valid),
        .dreq_i          (dreq),
        .dcredit_o       (dcredit),
        .dresp_valid_o   (dresp_valid),
        .dresp_o         (dresp),
        .flush_i         (flush),
        .cmd_valid_i     (cmd_valid),
        .cmd_i           (cmd),
        .cmd_rsp_valid_o (cmd_rsp_valid),
        .cmd_rsp_o       (cmd_rsp)
    );

    mmu_checker u_chk (
        .clk             (clk),
        .rst             (rst),
        .fetch_rsp_i     (fetch_rsp),
        .dreq_valid_i    (dreq_valid),
        .dcredit_i       (dcredit),
        .dresp_valid_i   (dresp_valid),
        .dresp_i         (dresp),
        .cmd_rsp_valid_i (cmd_rsp_valid),
        .cmd_rsp_i       (cmd_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // requester side credit count
    always @(posedge clk) begin
        if (rst) begin
            credits = mmu_pkg::DREQ_DEPTH;
        end else if (dcredit) begin
            credits++;
        end
    end

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic wait_credits(input int need);
        int t;
        t = 0;
        while ((credits < need) && !aborted) begin
            @(negedge clk);
            t++;
            if (t > WAIT_LIMIT) begin
                $display("timeout after %0d cycles waiting for data credits", WAIT_LIMIT);
                aborted = 1'b1;
            end
        end
    endtask

    task automatic issue_cmd(input mmu_pkg::tlb_cmd_e op, input logic [31:0] idx,
                             input logic [31:0] mask, input logic [31:0] hi,
                             input logic [31:0] lo0, input logic [31:0] lo1);
        cmd_valid = 1'b1;
        cmd.op    = op;
        cmd.idx   = idx[mmu_pkg::IDX_BITS-1:0];
        cmd.mask  = mask[11:0];
        cmd.hi    = hi;
        cmd.lo0   = lo0;
        cmd.lo1   = lo1;
        @(negedge clk);
        cmd_valid = 1'b0;
        cmd.op    = mmu_pkg::CMD_NONE;
    endtask

    task automatic fetch_check(input logic [31:0] va, input logic [31:0] pa,
                               input logic [31:0] miss, input logic [31:0] valid);
        fetch_va = va;
        u_chk.set_fetch(pa, miss[0], valid[0]);
        @(negedge clk);
    endtask

    // a flushed request goes alone so its result registers in the next cycle
    task automatic data_request(input logic [31:0] va, input logic [31:0] pa,
                                input logic [31:0] miss, input logic [31:0] valid,
                                input logic [31:0] dirty, input logic [31:0] fl);
        wait_credits(fl[0] ? mmu_pkg::DREQ_DEPTH : 1);
        if (!aborted) begin
            dreq_valid = 1'b1;
            dreq.va    = va;
            credits--;
            if (!fl[0]) begin
                u_chk.push_data(pa, miss[0], valid[0], dirty[0]);
            end
            @(negedge clk);
            dreq_valid = 1'b0;
            if (fl[0]) begin
                flush = 1'b1;
                @(negedge clk);
                flush = 1'b0;
            end
        end
    endtask

    initial begin
        int t;
        rst        = 1'b1;
        fetch_va   = '0;
        dreq_valid = 1'b0;
        dreq       = '0;
        flush      = 1'b0;
        cmd_valid  = 1'b0;
        cmd        = '0;
        aborted    = 1'b0;
        void'($urandom(32'h49cb));
        repeat (4) @(negedge clk);
        rst = 1'b0;

        fd = $fopen("test/mmu_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/mmu_golden.txt");
            aborted = 1'b1;
        end
        while (!aborted) begin
            code = $fscanf(fd, "%s", kind);
            if (code != 1) begin
                break;
            end
            if (kind == "#") begin
                code = $fgets(rest, fd);
            end else if (kind == "write") begin
                code = $fscanf(fd, "%h %h %h %h %h", f[0], f[1], f[2], f[3], f[4]);
                issue_cmd(mmu_pkg::CMD_TLBWI, f[0], f[1], f[2], f[3], f[4]);
            end else if (kind == "read") begin
                code = $fscanf(fd, "%h %h %h %h %h", f[0], f[1], f[2], f[3], f[4]);
                issue_cmd(mmu_pkg::CMD_TLBR, f[0], '0, '0, '0, '0);
                u_chk.await_reply(1'b0, f[1][11:0], f[2], f[3], f[4], '0);
            end else if (kind == "probe") begin
                code = $fscanf(fd, "%h %h", f[0], f[1]);
                issue_cmd(mmu_pkg::CMD_TLBP, '0, '0, f[0], '0, '0);
                u_chk.await_reply(1'b1, '0, '0, '0, '0, f[1]);
            end else if (kind == "fetch") begin
                code = $fscanf(fd, "%h %h %h %h", f[0], f[1], f[2], f[3]);
                fetch_check(f[0], f[1], f[2], f[3]);
            end else if (kind == "data") begin
                code = $fscanf(fd, "%h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]);
                data_request(f[0], f[1], f[2], f[3], f[4], f[5]);
            end else begin
                $display("unknown line kind in the golden file");
                aborted = 1'b1;
            end
            idle_cycles($urandom % 3);
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        // every credit back and every result seen
        t = 0;
        while (!aborted && ((credits != mmu_pkg::DREQ_DEPTH) || (u_chk.pending_data() != 0))) begin
            @(negedge clk);
            t++;
            if (t > WAIT_LIMIT) begin
                $display("timeout waiting for outstanding data results and credits");
                aborted = 1'b1;
            end
        end
        idle_cycles(2);
        u_chk.print_counts();
        if (!aborted && (u_chk.error_total() == 0)) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
